// ==== Bender.yml ====
package:
  name: ddr_test_driver

sources:
  - hw/ddr_test_pkg.sv
  - hw/lfsr_lane.sv
  - hw/address_gen.sv
  - hw/test_sequencer.sv
  - hw/write_pattern_gen.sv
  - hw/read_checker.sv
  - hw/ddr_test_driver.sv
  - target: test
    files:
      - bench/sdram_model.sv
      - bench/ddr_test_driver_tb.sv

// ==== bench/ddr_test_driver_tb.sv ====
// testbench for the ddr traffic generator, runs a table of stall and fault scenarios on a memory model
`timescale 1ns/10ps

module ddr_test_driver_tb;

  localparam int MAX_ROW          = 3;
  localparam int MAX_COL          = 16;
  localparam int MAX_BANK         = 3;
  localparam int CLK_PERIOD       = 4;
  localparam int DRIVE_DELAY      = 1;
  localparam int RESET_CYCLES     = 3;
  localparam int FIRST_REQ_CYCLES = 2;
  localparam int FAULT_DELAY      = 3;
  localparam int NO_FAULT         = -1;
  localparam int NUM_ROWS         = 6;

  // accesses per round from the address rules
  localparam int SEQ_BEATS    = (MAX_COL / ddr_test_pkg::COL_STEP + 1) * (MAX_ROW + 1)
                                * (MAX_BANK + 1);
  localparam int WALK_BEATS   = 2 * ddr_test_pkg::ROW_W + 1;
  localparam int ROUND_WRITES = 3 * SEQ_BEATS + WALK_BEATS;
  localparam int ROUND_CYCLES = ROUND_WRITES + (2 * SEQ_BEATS + WALK_BEATS) + RESET_CYCLES + 32;

  typedef struct {
    string name;
    int    stall_pct;
    int    fault_lane;
    int    fault_beat;
    logic  exp_persist;
    int    exp_writes;
  } scenario_t;

  logic                                clk = 1'b0;
  logic                                reset_n = 1'b0;
  logic                                local_ready;
  logic [ddr_test_pkg::DATA_W-1:0]     local_rdata;
  logic                                local_rdata_valid;
  logic                                write_req;
  logic                                read_req;
  logic                                burst_begin;
  logic [ddr_test_pkg::BANK_W-1:0]     bank;
  logic [ddr_test_pkg::ROW_W-1:0]      row;
  logic [ddr_test_pkg::COL_W-1:0]      col;
  ddr_test_pkg::mem_cmd_t              cmd;
  logic [ddr_test_pkg::DATA_W-1:0]     wdata;
  logic [ddr_test_pkg::LANES-1:0]      be;
  logic [ddr_test_pkg::LANES-1:0]      pnf_per_byte;
  logic                                pnf_persist;
  logic                                test_complete;
  logic [7:0]                          test_status;
  int                                  stall_pct = 0;
  int                                  fault_lane = NO_FAULT;
  int                                  fault_beat = 0;
  string                               cur_name = "reset";
  int                                  errors = 0;
  int                                  checks = 0;
  scenario_t                           rows [NUM_ROWS];

  // monitor state
  bit                                  written [logic [23:0]];
  int                                  writes;
  int                                  reads;
  int                                  seq_writes;
  int                                  mask_writes;
  int                                  pin_writes;
  int                                  beat_idx;
  int                                  idle_cycles;
  int                                  fault_wait;
  bit                                  seen_req;
  bit                                  fault_seen;
  bit                                  hold_pending;
  logic [3:0]                          prev_active;
  logic [11:0]                         test_order;
  ddr_test_pkg::mem_cmd_t              held_cmd;
  logic [ddr_test_pkg::DATA_W-1:0]     held_wdata;
  logic [ddr_test_pkg::LANES-1:0]      held_be;

  assign cmd = {write_req, read_req, burst_begin, bank, row, col};

  ddr_test_driver #(
    .MAX_ROW  (MAX_ROW),
    .MAX_COL  (MAX_COL),
    .MAX_BANK (MAX_BANK)
  ) DUT (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .local_write_req   (write_req),
    .local_read_req    (read_req),
    .local_burstbegin  (burst_begin),
    .local_bank_addr   (bank),
    .local_row_addr    (row),
    .local_col_addr    (col),
    .local_wdata       (wdata),
    .local_be          (be),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist),
    .test_complete     (test_complete),
    .test_status       (test_status)
  );

  sdram_model #(
    .LATENCY     (3),
    .DRIVE_DELAY (DRIVE_DELAY)
  ) u_memory (
    .clk         (clk),
    .reset_n     (reset_n),
    .cmd         (cmd),
    .wdata       (wdata),
    .be          (be),
    .stall_pct   (stall_pct),
    .fault_lane  (fault_lane),
    .fault_beat  (fault_beat),
    .ready       (local_ready),
    .rdata       (local_rdata),
    .rdata_valid (local_rdata_valid)
  );

  initial
  begin
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic check_equal(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    assert (actual === expected)
    else
    begin
      errors++;
      $display("error %s: %s expected %0h actual %0h", cur_name, what, expected, actual);
    end
  endtask

  task automatic run_scenario(input scenario_t sc);
    @(posedge clk);
    #DRIVE_DELAY;
    cur_name   = sc.name;
    stall_pct  = sc.stall_pct;
    fault_lane = sc.fault_lane;
    fault_beat = sc.fault_beat;
    reset_n    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset_n = 1'b1;
    while (test_complete !== 1'b1)
      @(negedge clk);
    check_equal("pnf_persist at test_complete", sc.exp_persist, pnf_persist);
    if (sc.fault_lane == NO_FAULT)
      check_equal("pnf_per_byte at test_complete", 8'hff, pnf_per_byte);
    else
      check_equal("faulty beat reached", 1, fault_seen);
    check_equal("test_status at test_complete", 8'h80, test_status);
    check_equal("accepted writes", sc.exp_writes, writes);
    // the zero-clearing pass is never read back
    check_equal("accepted reads", sc.exp_writes - SEQ_BEATS, reads);
    check_equal("sequential address writes", SEQ_BEATS, seq_writes);
    check_equal("data mask writes", 2 * SEQ_BEATS, mask_writes);
    check_equal("address pin writes", WALK_BEATS, pin_writes);
    check_equal("test order", 12'h148, test_order);
    @(negedge clk);
    check_equal("test_complete width", 0, test_complete);
    check_equal("pnf_persist after test_complete", sc.exp_persist, pnf_persist);
  endtask

  // --------------------
  // scenario table
  initial
  begin
    rows[0] = '{"no_stall", 0, NO_FAULT, 0, 1'b1, ROUND_WRITES};
    rows[1] = '{"stall_25", 25, NO_FAULT, 0, 1'b1, ROUND_WRITES};
    rows[2] = '{"stall_50", 50, NO_FAULT, 0, 1'b1, ROUND_WRITES};
    rows[3] = '{"fault_seq_lane3", 20, 3, 10, 1'b0, ROUND_WRITES};
    rows[4] = '{"fault_mask_lane6", 20, 6, SEQ_BEATS + 20, 1'b0, ROUND_WRITES};
    rows[5] = '{"fault_walk_lane0", 35, 0, 2 * SEQ_BEATS + 5, 1'b0, ROUND_WRITES};
    for (int r = 0; r < NUM_ROWS; r++)
      run_scenario(rows[r]);
    $display("%0d errors in %0d checks over %0d scenarios", errors, checks, NUM_ROWS);
    if (errors == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  initial
  begin : watchdog
    #(NUM_ROWS * ROUND_CYCLES * 4 * CLK_PERIOD);
    $display("watchdog expired at %0t before the scenario table finished", $time);
    $display("%0d errors in %0d checks", errors, checks);
    $display("tests failed");
    $finish;
  end

  // --------------------
  // port monitor, sampled mid-cycle
  always @(negedge clk)
  begin : monitor
    logic [3:0]             active;
    logic [7:0]             fault_mask;
    ddr_test_pkg::mem_cmd_t cmd_level;
    active              = test_status[3:0];
    cmd_level           = cmd;
    cmd_level.burst_begin = 1'b0;
    if (!reset_n)
    begin
      written.delete();
      {writes, reads, seq_writes, mask_writes, pin_writes} = '0;
      {beat_idx, idle_cycles, fault_wait} = '0;
      {seen_req, fault_seen, hold_pending} = '0;
      prev_active = '0;
      test_order  = '0;
      check_equal("outputs in reset", 0,
                  {write_req, read_req, burst_begin, test_complete, pnf_persist});
    end
    else
    begin
      if (!seen_req && (write_req || read_req))
      begin
        seen_req = 1'b1;
        check_equal("cycles to first request", FIRST_REQ_CYCLES, idle_cycles);
      end
      else if (!seen_req)
      begin
        idle_cycles++;
        check_equal("outputs before first request", 0, {burst_begin, test_complete, pnf_persist});
      end
      check_equal("test_status one-hot", 1, $onehot0(test_status));
      check_equal("test_status unused bits", 0, test_status & 8'h72);
      if (active != prev_active)
      begin
        written.delete();
        if (active != 0)
          test_order = {test_order[7:0], active};
        prev_active = active;
      end
      // under back-pressure the beat stays put
      if (hold_pending)
      begin
        check_equal("held command", held_cmd, cmd_level);
        check_equal("burst_begin on held beat", 0, burst_begin);
        if (held_cmd.write_req)
        begin
          check_equal("held wdata", held_wdata, wdata);
          check_equal("held be", held_be, be);
        end
      end
      else
        check_equal("burst_begin on new beat", write_req || read_req, burst_begin);
      hold_pending = (write_req || read_req) && !local_ready;
      held_cmd     = cmd_level;
      held_wdata   = wdata;
      held_be      = be;
      if (write_req && local_ready)
      begin
        writes++;
        seq_writes  += (active == 4'h1);
        mask_writes += (active == 4'h4);
        pin_writes  += (active == 4'h8);
        written[cmd.addr] = 1'b1;
      end
      if (read_req && local_ready)
      begin
        reads++;
        checks++;
        assert (written.exists(cmd.addr))
        else
        begin
          errors++;
          $display("%s: read from address %h that was not written in this test",
                   cur_name, cmd.addr);
        end
      end
      if (fault_wait > 0)
      begin
        fault_wait--;
        if (fault_wait == 0)
        begin
          fault_mask = ~(8'h01 << fault_lane);
          check_equal("pnf_per_byte after faulty beat", fault_mask, pnf_per_byte);
          fault_seen = 1'b1;
        end
      end
      if (local_rdata_valid)
      begin
        if (fault_lane != NO_FAULT && beat_idx == fault_beat)
          fault_wait = FAULT_DELAY;
        beat_idx++;
      end
    end
  end

endmodule

// ==== bench/sdram_model.sv ====
// behavioral ddr local port memory for the bench, with byte enables, ready stalls and read faults
`timescale 1ns/10ps

module sdram_model #(
  parameter int LATENCY     = 3,
  parameter int DRIVE_DELAY = 1
) (
  input  logic                            clk,
  input  logic                            reset_n,
  input  ddr_test_pkg::mem_cmd_t          cmd,
  input  logic [ddr_test_pkg::DATA_W-1:0] wdata,
  input  logic [ddr_test_pkg::LANES-1:0]  be,
  input  int                              stall_pct,
  input  int                              fault_lane,
  input  int                              fault_beat,
  output logic                            ready,
  output logic [ddr_test_pkg::DATA_W-1:0] rdata,
  output logic                            rdata_valid
);

  localparam int AW = $bits(ddr_test_pkg::mem_addr_t);
  localparam int DW = ddr_test_pkg::DATA_W;

  logic [DW-1:0] mem [logic [AW-1:0]];
  logic          pipe_valid [LATENCY];
  logic [AW-1:0] pipe_addr [LATENCY];
  integer        seed;
  int            beat;

  // unwritten words read back as a pattern of the whole address
  function automatic logic [DW-1:0] fill_word(input logic [AW-1:0] key);
    return {key, ~key, key[15:0]};
  endfunction

  function automatic logic [DW-1:0] read_word(input logic [AW-1:0] key);
    return mem.exists(key) ? mem[key] : fill_word(key);
  endfunction

  initial
  begin
    seed        = 38;
    beat        = 0;
    ready       = 1'b0;
    rdata       = '0;
    rdata_valid = 1'b0;
    for (int i = 0; i < LATENCY; i++)
    begin
      pipe_valid[i] = 1'b0;
      pipe_addr[i]  = '0;
    end
  end

  always @(posedge clk)
  begin : port_cycle
    logic [DW-1:0] word;
    int            roll;
    word = '0;
    if (!reset_n)
    begin
      beat = 0;
      for (int i = 0; i < LATENCY; i++)
        pipe_valid[i] = 1'b0;
    end
    else
    begin
      // a write lands at once, only enabled lanes change
      if (cmd.write_req && ready)
      begin
        word = read_word(cmd.addr);
        for (int i = 0; i < ddr_test_pkg::LANES; i++)
          if (be[i])
            word[8*i +: 8] = wdata[8*i +: 8];
        mem[cmd.addr] = word;
      end
      for (int i = LATENCY - 1; i > 0; i--)
      begin
        pipe_valid[i] = pipe_valid[i-1];
        pipe_addr[i]  = pipe_addr[i-1];
      end
      pipe_valid[0] = cmd.read_req && ready;
      pipe_addr[0]  = cmd.addr;
    end
    #DRIVE_DELAY;
    roll        = $unsigned($random(seed)) % 100;
    ready       = (roll >= stall_pct);
    rdata_valid = pipe_valid[LATENCY-1];
    rdata       = '0;
    if (pipe_valid[LATENCY-1])
    begin
      word = read_word(pipe_addr[LATENCY-1]);
      // flip bit 0 of the chosen lane on the chosen beat
      if (beat == fault_beat && fault_lane >= 0 && fault_lane < ddr_test_pkg::LANES)
        word[8*fault_lane] = ~word[8*fault_lane];
      rdata = word;
      beat++;
    end
  end

endmodule

// ==== hw/address_gen.sv ====
// bank/row/column counter for the tests, sequential sweep or walking-one row pattern
`timescale 1ns/10ps

module address_gen #(
  parameter int MAX_ROW  = 3,
  parameter int MAX_COL  = 16,
  parameter int MAX_BANK = 3
) (
  input  logic                     clk,
  input  logic                     reset_n,
  input  ddr_test_pkg::test_mode_t mode,
  input  logic                     addr_step,
  input  logic                     addr_clear,
  output ddr_test_pkg::mem_addr_t  addr,
  output logic                     at_end
);

  localparam int RW = ddr_test_pkg::ROW_W;
  localparam int CW = ddr_test_pkg::COL_W;
  localparam int BW = ddr_test_pkg::BANK_W;

  localparam logic [RW-1:0] ROW_LAST  = RW'(MAX_ROW);
  localparam logic [CW-1:0] COL_LAST  = CW'(MAX_COL);
  localparam logic [BW-1:0] BANK_LAST = BW'(MAX_BANK);
  localparam logic [RW-1:0] ROW_TOP   = {1'b1, {(RW-1){1'b0}}};

  logic          walk;
  logic [BW-1:0] bank_next;

  assign walk      = (mode == ddr_test_pkg::MODE_ADDR_PIN);
  assign bank_next = (addr.bank == BANK_LAST) ? '0 : addr.bank + 1'b1;

  // last address of the range for the active pattern
  assign at_end = walk ? (&addr.row)
                       : (addr.col >= COL_LAST && addr.row == ROW_LAST && addr.bank == BANK_LAST);

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      addr <= '0;
    else if (addr_clear)
    begin
      addr <= '0;
      // walking pattern opens on row 1, column 4
      if (walk)
      begin
        addr.row <= RW'(1);
        addr.col <= CW'(ddr_test_pkg::COL_STEP);
      end
    end
    else if (addr_step && walk)
    begin
      addr.bank <= bank_next;
      if (addr.row == ROW_TOP)
      begin
        addr.row <= ~RW'(1);
        addr.col <= {{(CW-3){1'b1}}, 3'b000};
      end
      else if (addr.row == ~ROW_TOP)
      begin
        addr.row <= '1;
        addr.col <= {{(CW-2){1'b1}}, 2'b00};
      end
      else
      begin
        addr.row          <= {addr.row[RW-2:0], addr.row[RW-1]};
        addr.col[CW-1:2] <= {addr.col[CW-2:2], addr.col[CW-1]};
      end
    end
    else if (addr_step)
    begin
      // column, then row, then bank
      if (addr.col >= COL_LAST)
      begin
        addr.col <= '0;
        if (addr.row == ROW_LAST)
        begin
          addr.row  <= '0;
          addr.bank <= bank_next;
        end
        else
          addr.row <= addr.row + 1'b1;
      end
      else
        addr.col <= addr.col + CW'(ddr_test_pkg::COL_STEP);
    end
  end

endmodule

// ==== hw/ddr_test_driver.sv ====
// top of the self-checking ddr local port traffic generator, drives the port and reports pass flags
`timescale 1ns/10ps

module ddr_test_driver #(
  parameter int MAX_ROW  = 3,
  parameter int MAX_COL  = 16,
  parameter int MAX_BANK = 3
) (
  input  logic                                clk,
  input  logic                                reset_n,
  input  logic                                local_ready,
  input  logic [ddr_test_pkg::DATA_W-1:0]     local_rdata,
  input  logic                                local_rdata_valid,
  output logic                                local_write_req,
  output logic                                local_read_req,
  output logic                                local_burstbegin,
  output logic [ddr_test_pkg::BANK_W-1:0]     local_bank_addr,
  output logic [ddr_test_pkg::ROW_W-1:0]      local_row_addr,
  output logic [ddr_test_pkg::COL_W-1:0]      local_col_addr,
  output logic [ddr_test_pkg::DATA_W-1:0]     local_wdata,
  output logic [ddr_test_pkg::LANES-1:0]      local_be,
  output logic [ddr_test_pkg::LANES-1:0]      pnf_per_byte,
  output logic                                pnf_persist,
  output logic                                test_complete,
  output logic [7:0]                          test_status
);

  ddr_test_pkg::test_mode_t        mode;
  ddr_test_pkg::mem_cmd_t          seq_cmd;
  ddr_test_pkg::mem_cmd_t          cmd;
  ddr_test_pkg::mem_addr_t         addr;
  logic                            at_end;
  logic                            addr_step;
  logic                            addr_clear;
  logic                            load_pattern;
  logic                            clear_data;
  logic                            be_reset;
  logic                            capture_seed;
  logic                            advance;
  logic [ddr_test_pkg::DATA_W-1:0] expect_data;

  // request bits from the sequencer, address from the counter
  assign cmd = '{
    write_req:   seq_cmd.write_req,
    read_req:    seq_cmd.read_req,
    burst_begin: seq_cmd.burst_begin,
    addr:        addr
  };

  assign local_write_req  = cmd.write_req;
  assign local_read_req   = cmd.read_req;
  assign local_burstbegin = cmd.burst_begin;
  assign local_bank_addr  = cmd.addr.bank;
  assign local_row_addr   = cmd.addr.row;
  assign local_col_addr   = cmd.addr.col;

  // generators step on every accepted write and every returned beat
  assign advance = (cmd.write_req & local_ready) | local_rdata_valid;

  // one status bit per active test, bit 1 was the incomplete-write test
  assign test_status = {
    test_complete,
    3'b000,
    mode == ddr_test_pkg::MODE_ADDR_PIN,
    mode == ddr_test_pkg::MODE_DATA_MASK,
    1'b0,
    mode == ddr_test_pkg::MODE_SEQ_ADDR
  };

  test_sequencer u_sequencer (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_ready       (local_ready),
    .local_rdata_valid (local_rdata_valid),
    .at_end            (at_end),
    .mode              (mode),
    .cmd               (seq_cmd),
    .addr_step         (addr_step),
    .addr_clear        (addr_clear),
    .load_pattern      (load_pattern),
    .clear_data        (clear_data),
    .be_reset          (be_reset),
    .capture_seed      (capture_seed),
    .test_complete     (test_complete)
  );

  address_gen #(
    .MAX_ROW  (MAX_ROW),
    .MAX_COL  (MAX_COL),
    .MAX_BANK (MAX_BANK)
  ) u_address_gen (
    .clk        (clk),
    .reset_n    (reset_n),
    .mode       (mode),
    .addr_step  (addr_step),
    .addr_clear (addr_clear),
    .addr       (addr),
    .at_end     (at_end)
  );

  write_pattern_gen u_pattern_gen (
    .clk          (clk),
    .reset_n      (reset_n),
    .mode         (mode),
    .advance      (advance),
    .load_pattern (load_pattern),
    .clear_data   (clear_data),
    .be_reset     (be_reset),
    .capture_seed (capture_seed),
    .wdata        (local_wdata),
    .expect_data  (expect_data),
    .be           (local_be)
  );

  read_checker u_read_checker (
    .clk               (clk),
    .reset_n           (reset_n),
    .local_rdata       (local_rdata),
    .local_rdata_valid (local_rdata_valid),
    .expect_data       (expect_data),
    .be                (local_be),
    .pnf_per_byte      (pnf_per_byte),
    .pnf_persist       (pnf_persist)
  );

endmodule

// ==== hw/ddr_test_pkg.sv ====
// shared widths, command structs, lane seeds and enums for the ddr traffic generator and its bench
package ddr_test_pkg;

  // local port geometry
  localparam int DATA_W   = 64;
  localparam int LANES    = 8;
  localparam int ROW_W    = 13;
  localparam int COL_W    = 9;
  localparam int BANK_W   = 2;

  // column advance per one-beat access
  localparam int COL_STEP = 4;

  // lfsr seed per byte lane, lane 0 is the low entry
  localparam logic [LANES-1:0][7:0] LANE_SEEDS = {
    8'd71, 8'd61, 8'd51, 8'd41, 8'd31, 8'd21, 8'd11, 8'd1
  };

  typedef struct packed {
    logic [BANK_W-1:0] bank;
    logic [ROW_W-1:0]  row;
    logic [COL_W-1:0]  col;
  } mem_addr_t;

  typedef struct packed {
    logic      write_req;
    logic      read_req;
    logic      burst_begin;
    mem_addr_t addr;
  } mem_cmd_t;

  typedef enum logic [1:0] {
    MODE_SEQ_ADDR,
    MODE_DATA_MASK,
    MODE_ADDR_PIN,
    MODE_NONE
  } test_mode_t;

  typedef enum logic [3:0] {
    ST_INIT,
    ST_START,
    ST_CLEAR_WRITE,
    ST_CLEAR_DRAIN,
    ST_RELOAD,
    ST_WRITE,
    ST_WRITE_DRAIN,
    ST_READ,
    ST_READ_DRAIN,
    ST_DONE
  } seq_state_t;

endpackage

// ==== hw/lfsr_lane.sv ====
// one byte lane of the data pattern generator, an 8-bit maximal-length lfsr with reload
`timescale 1ns/10ps

module lfsr_lane #(
  parameter logic [7:0] SEED = 8'd1
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       enable,
  input  logic       load,
  input  logic       pause,
  input  logic [7:0] ldata,
  output logic [7:0] data
);

  logic feedback;

  // taps for x^8 + x^6 + x^5 + x^4 + 1
  assign feedback = data[7] ^ data[5] ^ data[4] ^ data[3];

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      data <= SEED;
    else if (load)
      data <= ldata;
    else if (enable && !pause)
      data <= {data[6:0], feedback};
  end

endmodule

// ==== hw/read_checker.sv ====
// read-back comparator, per-lane pass flags and a sticky overall pass flag
`timescale 1ns/10ps

module read_checker (
  input  logic                            clk,
  input  logic                            reset_n,
  input  logic [ddr_test_pkg::DATA_W-1:0] local_rdata,
  input  logic                            local_rdata_valid,
  input  logic [ddr_test_pkg::DATA_W-1:0] expect_data,
  input  logic [ddr_test_pkg::LANES-1:0]  be,
  output logic [ddr_test_pkg::LANES-1:0]  pnf_per_byte,
  output logic                            pnf_persist
);

  localparam int NL = ddr_test_pkg::LANES;

  logic [NL-1:0] compare;
  logic [NL-1:0] compare_reg;
  logic [NL-1:0] compare_hold;
  logic          last_valid;
  logic [2:0]    seen;
  logic          persist_int;

  // masked lanes expect the zeros of the clearing pass
  always_comb
  begin
    for (int i = 0; i < NL; i++)
      compare[i] = (expect_data[8*i +: 8] & {8{be[i]}}) == local_rdata[8*i +: 8];
  end

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      compare_reg  <= '1;
      compare_hold <= '1;
      pnf_per_byte <= '1;
      last_valid   <= 1'b0;
      seen         <= '0;
      persist_int  <= 1'b0;
      pnf_persist  <= 1'b0;
    end
    else
    begin
      compare_reg <= compare;
      last_valid  <= local_rdata_valid;
      // first read seen, delayed to line up with the compare stages
      seen <= {seen[1:0], seen[0] | local_rdata_valid};
      if (last_valid)
        compare_hold <= compare_reg;
      pnf_per_byte <= compare_hold;
      persist_int  <= (&compare_hold) & seen[1] & (persist_int | ~seen[2]);
      pnf_persist  <= persist_int;
    end
  end

endmodule

// ==== hw/test_sequencer.sv ====
// test loop controller, runs write, reload and read phases for each test and tracks open reads
`timescale 1ns/10ps

module test_sequencer (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     local_ready,
  input  logic                     local_rdata_valid,
  input  logic                     at_end,
  output ddr_test_pkg::test_mode_t mode,
  output ddr_test_pkg::mem_cmd_t   cmd,
  output logic                     addr_step,
  output logic                     addr_clear,
  output logic                     load_pattern,
  output logic                     clear_data,
  output logic                     be_reset,
  output logic                     capture_seed,
  output logic                     test_complete
);

  ddr_test_pkg::seq_state_t state;
  logic                     write_req;
  logic                     read_req;
  logic                     burst_begin;
  logic                     accept;
  logic [5:0]               rd_count;

  assign accept    = (write_req | read_req) & local_ready;
  assign addr_step = accept;

  // address is filled in at the top level
  assign cmd = '{
    write_req:   write_req,
    read_req:    read_req,
    burst_begin: burst_begin,
    addr:        '0
  };

  // one-cycle strobes decoded from the state
  assign capture_seed = (state == ddr_test_pkg::ST_START);
  assign addr_clear   = state inside {ddr_test_pkg::ST_START, ddr_test_pkg::ST_CLEAR_DRAIN,
                                      ddr_test_pkg::ST_RELOAD};
  assign load_pattern = state inside {ddr_test_pkg::ST_CLEAR_DRAIN, ddr_test_pkg::ST_RELOAD};
  assign be_reset     = load_pattern;

  // --------------------
  // outstanding reads
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      rd_count <= '0;
    else
    begin
      case ({read_req & local_ready, local_rdata_valid})
        2'b10:   rd_count <= rd_count + 1'b1;
        2'b01:   rd_count <= rd_count - 1'b1;
        default: rd_count <= rd_count;
      endcase
    end
  end

  // --------------------
  // phase state machine
  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
    begin
      state         <= ddr_test_pkg::ST_INIT;
      mode          <= ddr_test_pkg::MODE_NONE;
      write_req     <= 1'b0;
      read_req      <= 1'b0;
      burst_begin   <= 1'b0;
      clear_data    <= 1'b0;
      test_complete <= 1'b0;
    end
    else
    begin
      case (state)
        ddr_test_pkg::ST_INIT:
        begin
          test_complete <= 1'b0;
          mode          <= ddr_test_pkg::MODE_SEQ_ADDR;
          state         <= ddr_test_pkg::ST_START;
        end
        ddr_test_pkg::ST_START:
        begin
          write_req   <= 1'b1;
          burst_begin <= 1'b1;
          // mask test zeroes its range first
          if (mode == ddr_test_pkg::MODE_DATA_MASK)
          begin
            clear_data <= 1'b1;
            state      <= ddr_test_pkg::ST_CLEAR_WRITE;
          end
          else
            state <= ddr_test_pkg::ST_WRITE;
        end
        ddr_test_pkg::ST_CLEAR_WRITE, ddr_test_pkg::ST_WRITE:
        begin
          // a new beat only follows an accepted one
          burst_begin <= accept & ~at_end;
          if (accept && at_end)
          begin
            write_req <= 1'b0;
            if (state == ddr_test_pkg::ST_CLEAR_WRITE)
              state <= ddr_test_pkg::ST_CLEAR_DRAIN;
            else
              state <= ddr_test_pkg::ST_WRITE_DRAIN;
          end
        end
        ddr_test_pkg::ST_CLEAR_DRAIN:
        begin
          clear_data  <= 1'b0;
          write_req   <= 1'b1;
          burst_begin <= 1'b1;
          state       <= ddr_test_pkg::ST_WRITE;
        end
        ddr_test_pkg::ST_WRITE_DRAIN:
          state <= ddr_test_pkg::ST_RELOAD;
        ddr_test_pkg::ST_RELOAD:
        begin
          read_req    <= 1'b1;
          burst_begin <= 1'b1;
          state       <= ddr_test_pkg::ST_READ;
        end
        ddr_test_pkg::ST_READ:
        begin
          burst_begin <= accept & ~at_end;
          if (accept && at_end)
          begin
            read_req <= 1'b0;
            state    <= ddr_test_pkg::ST_READ_DRAIN;
          end
        end
        ddr_test_pkg::ST_READ_DRAIN:
        begin
          // wait for every read beat before the next test
          if (rd_count == '0)
          begin
            case (mode)
              ddr_test_pkg::MODE_SEQ_ADDR:
              begin
                mode  <= ddr_test_pkg::MODE_DATA_MASK;
                state <= ddr_test_pkg::ST_START;
              end
              ddr_test_pkg::MODE_DATA_MASK:
              begin
                mode  <= ddr_test_pkg::MODE_ADDR_PIN;
                state <= ddr_test_pkg::ST_START;
              end
              default:
              begin
                mode  <= ddr_test_pkg::MODE_NONE;
                state <= ddr_test_pkg::ST_DONE;
              end
            endcase
          end
        end
        ddr_test_pkg::ST_DONE:
        begin
          test_complete <= 1'b1;
          state         <= ddr_test_pkg::ST_INIT;
        end
        default:
          state <= ddr_test_pkg::ST_INIT;
      endcase
    end
  end

  // --------------------
  // protocol checks
  a_req_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(write_req && read_req));

  // every returned beat belongs to an accepted read
  a_rd_no_underflow: assert property (@(posedge clk) disable iff (!reset_n)
    local_rdata_valid |-> (rd_count != '0));

endmodule

// ==== hw/write_pattern_gen.sv ====
// write data and byte-enable source, replays the same pattern as expected data on read-back
`timescale 1ns/10ps

module write_pattern_gen (
  input  logic                            clk,
  input  logic                            reset_n,
  input  ddr_test_pkg::test_mode_t        mode,
  input  logic                            advance,
  input  logic                            load_pattern,
  input  logic                            clear_data,
  input  logic                            be_reset,
  input  logic                            capture_seed,
  output logic [ddr_test_pkg::DATA_W-1:0] wdata,
  output logic [ddr_test_pkg::DATA_W-1:0] expect_data,
  output logic [ddr_test_pkg::LANES-1:0]  be
);

  localparam int NL = ddr_test_pkg::LANES;

  logic [NL-1:0][7:0] lane_data;
  logic [NL-1:0][7:0] seed_reg;
  logic               masked;

  // lanes hold through the zero-clearing pass
  for (genvar i = 0; i < NL; i++)
  begin : g_lane
    lfsr_lane #(
      .SEED (ddr_test_pkg::LANE_SEEDS[i])
    ) u_lane (
      .clk     (clk),
      .reset_n (reset_n),
      .enable  (advance),
      .load    (load_pattern),
      .pause   (clear_data),
      .ldata   (seed_reg[i]),
      .data    (lane_data[i])
    );
  end

  // lane state at test start, reloaded before the read pass
  always_ff @(posedge clk)
  begin
    if (capture_seed)
      seed_reg <= lane_data;
  end

  assign expect_data = lane_data;
  assign wdata       = clear_data ? '0 : lane_data;

  // --------------------
  // byte enables
  assign masked = (mode == ddr_test_pkg::MODE_DATA_MASK) && !clear_data;

  always_ff @(posedge clk or negedge reset_n)
  begin
    if (!reset_n)
      be <= '1;
    else if (mode != ddr_test_pkg::MODE_DATA_MASK)
      be <= '1;
    else if (be_reset)
      be <= NL'(1);
    else if (clear_data)
      be <= '1;
    else if (advance)
      be <= {be[NL-2:0], be[NL-1]};
  end

  // each masked beat writes or checks exactly one lane
  a_be_onehot: assert property (@(posedge clk) disable iff (!reset_n)
    (masked && advance) |-> $onehot(be));

endmodule

// ==== verilog.f ====
hw/ddr_test_pkg.sv
hw/lfsr_lane.sv
hw/address_gen.sv
hw/test_sequencer.sv
hw/write_pattern_gen.sv
hw/read_checker.sv
hw/ddr_test_driver.sv
bench/sdram_model.sv
bench/ddr_test_driver_tb.sv
